/* design/rv_decode_pkg.sv */
// Opcode constants, operator and mux enums, control bundle and ID/EX register types
package rv_decode_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Major opcodes (instr[6:0])
  ////////////////////////////////////////////////////////////////////////////
  localparam logic [6:0] OPCODE_OP     = 7'h33;
  localparam logic [6:0] OPCODE_OPIMM  = 7'h13;
  localparam logic [6:0] OPCODE_LOAD   = 7'h03;
  localparam logic [6:0] OPCODE_STORE  = 7'h23;
  localparam logic [6:0] OPCODE_BRANCH = 7'h63;
  localparam logic [6:0] OPCODE_JAL    = 7'h6f;
  localparam logic [6:0] OPCODE_JALR   = 7'h67;
  localparam logic [6:0] OPCODE_LUI    = 7'h37;
  localparam logic [6:0] OPCODE_AUIPC  = 7'h17;
  localparam logic [6:0] OPCODE_SYSTEM = 7'h73;
  localparam logic [6:0] OPCODE_FENCE  = 7'h0f;

  ////////////////////////////////////////////////////////////////////////////
  // Operators and mux selects
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU // Branch compares
  } alu_opcode_e;

  typedef enum logic [1:0] {
    MUL,  // Low word of product
    MULH  // High word, signedness from mul_signed_mode
  } mul_opcode_e;

  typedef enum logic [1:0] {DIV, DIVU, REM, REMU} div_opcode_e;

  typedef enum logic [1:0] {
    CSR_OP_READ, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR
  } csr_opcode_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_mux_e;

  typedef enum logic {OP_B_REG, OP_B_IMM} op_b_mux_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_mux_e;

  typedef enum logic [1:0] {
    BRANCH_NONE, BRANCH_JAL, BRANCH_JALR, BRANCH_COND
  } branch_e;

  ////////////////////////////////////////////////////////////////////////////
  // Control bundle produced by each sub-decoder
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic        alu_en;
    logic        mul_en;
    logic        div_en;
    logic        lsu_en;
    logic        csr_en;
    alu_opcode_e alu_operator;
    mul_opcode_e mul_operator;
    logic [1:0]  mul_signed_mode;  // [0] op a signed, [1] op b signed
    div_opcode_e div_operator;
    csr_opcode_e csr_op;
    op_a_mux_e   op_a_mux_sel;
    op_b_mux_e   op_b_mux_sel;
    imm_mux_e    imm_mux_sel;
    logic        rf_we;
    logic [1:0]  rf_re;            // [0] rs1, [1] rs2
    logic        lsu_we;
    logic [1:0]  lsu_type;         // 00 byte, 01 half, 10 word
    logic        lsu_sign_ext;
    branch_e     ctrl_transfer_insn;
    logic        mret_insn;
    logic        dret_insn;
    logic        ebrk_insn;
    logic        ecall_insn;
    logic        wfi_insn;
    logic        fencei_insn;
    logic        illegal_insn;
  } decoder_ctrl_t;

  // No match: nothing enabled, only the illegal flag
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL_INSN = '{
    alu_en:             1'b0,
    mul_en:             1'b0,
    div_en:             1'b0,
    lsu_en:             1'b0,
    csr_en:             1'b0,
    alu_operator:       ALU_ADD,
    mul_operator:       MUL,
    mul_signed_mode:    2'b00,
    div_operator:       DIV,
    csr_op:             CSR_OP_READ,
    op_a_mux_sel:       OP_A_REG,
    op_b_mux_sel:       OP_B_REG,
    imm_mux_sel:        IMM_I,
    rf_we:              1'b0,
    rf_re:              2'b00,
    lsu_we:             1'b0,
    lsu_type:           2'b00,
    lsu_sign_ext:       1'b0,
    ctrl_transfer_insn: BRANCH_NONE,
    mret_insn:          1'b0,
    dret_insn:          1'b0,
    ebrk_insn:          1'b0,
    ecall_insn:         1'b0,
    wfi_insn:           1'b0,
    fencei_insn:        1'b0,
    illegal_insn:       1'b1
  };

  // ID/EX stage register contents
  typedef struct packed {
    logic          valid;
    decoder_ctrl_t ctrl;                   // After suppression
    logic          rf_we_raw;              // Before suppression
    logic          lsu_en_raw;
    branch_e       ctrl_transfer_insn_raw;
  } id_ex_t;

endpackage

/* design/rv_i_decoder.sv */
// RV32I base instruction decoder producing a control bundle
`timescale 1ns/1ps

module rv_i_decoder (
  input  logic [31:0]                  instr_rdata_i,
  output rv_decode_pkg::decoder_ctrl_t decoder_ctrl_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_rdata_i[6:0];
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  always_comb begin
    decoder_ctrl_o = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
    decoder_ctrl_o.illegal_insn = 1'b0; // Restored below on bad encodings

    unique case (opcode)
      rv_decode_pkg::OPCODE_LUI, rv_decode_pkg::OPCODE_AUIPC: begin
        decoder_ctrl_o.alu_en       = 1'b1;
        decoder_ctrl_o.op_a_mux_sel = (opcode == rv_decode_pkg::OPCODE_LUI) ?
                                      rv_decode_pkg::OP_A_ZERO : rv_decode_pkg::OP_A_PC;
        decoder_ctrl_o.op_b_mux_sel = rv_decode_pkg::OP_B_IMM;
        decoder_ctrl_o.imm_mux_sel  = rv_decode_pkg::IMM_U;
        decoder_ctrl_o.rf_we        = 1'b1;
      end

      rv_decode_pkg::OPCODE_JAL: begin
        decoder_ctrl_o.alu_en             = 1'b1;              // Link address
        decoder_ctrl_o.op_a_mux_sel       = rv_decode_pkg::OP_A_PC;
        decoder_ctrl_o.op_b_mux_sel       = rv_decode_pkg::OP_B_IMM;
        decoder_ctrl_o.imm_mux_sel        = rv_decode_pkg::IMM_J;
        decoder_ctrl_o.rf_we              = 1'b1;
        decoder_ctrl_o.ctrl_transfer_insn = rv_decode_pkg::BRANCH_JAL;
      end

      rv_decode_pkg::OPCODE_JALR: begin
        decoder_ctrl_o.alu_en             = 1'b1;
        decoder_ctrl_o.op_b_mux_sel       = rv_decode_pkg::OP_B_IMM;
        decoder_ctrl_o.rf_re              = 2'b01;
        decoder_ctrl_o.rf_we              = 1'b1;
        decoder_ctrl_o.ctrl_transfer_insn = rv_decode_pkg::BRANCH_JALR;
        if (funct3 != 3'b000) decoder_ctrl_o = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
      end

      rv_decode_pkg::OPCODE_BRANCH: begin
        decoder_ctrl_o.alu_en             = 1'b1;              // Compare rs1 with rs2
        decoder_ctrl_o.imm_mux_sel        = rv_decode_pkg::IMM_B;
        decoder_ctrl_o.rf_re              = 2'b11;
        decoder_ctrl_o.ctrl_transfer_insn = rv_decode_pkg::BRANCH_COND;
        unique case (funct3)
          3'b000:  decoder_ctrl_o.alu_operator = rv_decode_pkg::ALU_EQ;
          3'b001:  decoder_ctrl_o.alu_operator = rv_decode_pkg::ALU_NE;
          3'b100:  decoder_ctrl_o.alu_operator = rv_decode_pkg::ALU_LT;
          3'b101:  decoder_ctrl_o.alu_operator = rv_decode_pkg::ALU_GE;
          3'b110:  decoder_ctrl_o.alu_operator = rv_decode_pkg::ALU_LTU;
          3'b111:  decoder_ctrl_o.alu_operator = rv_decode_pkg::ALU_GEU;
          default: decoder_ctrl_o = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
        endcase
      end

      rv_decode_pkg::OPCODE_LOAD: begin
        decoder_ctrl_o.lsu_en       = 1'b1;
        decoder_ctrl_o.op_b_mux_sel = rv_decode_pkg::OP_B_IMM;  // Address rs1 + imm
        decoder_ctrl_o.rf_re        = 2'b01;
        decoder_ctrl_o.rf_we        = 1'b1;
        decoder_ctrl_o.lsu_type     = funct3[1:0];
        decoder_ctrl_o.lsu_sign_ext = ~funct3[2];               // LBU/LHU zero extend
        if (funct3[1:0] == 2'b11 || funct3 == 3'b110) begin
          decoder_ctrl_o = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
        end
      end

      rv_decode_pkg::OPCODE_STORE: begin
        decoder_ctrl_o.lsu_en       = 1'b1;
        decoder_ctrl_o.lsu_we       = 1'b1;
        decoder_ctrl_o.op_b_mux_sel = rv_decode_pkg::OP_B_IMM;
        decoder_ctrl_o.imm_mux_sel  = rv_decode_pkg::IMM_S;
        decoder_ctrl_o.rf_re        = 2'b11;                    // Base and store data
        decoder_ctrl_o.lsu_type     = funct3[1:0];
        if (funct3[2] || funct3[1:0] == 2'b11) begin
          decoder_ctrl_o = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
        end
      end

      rv_decode_pkg::OPCODE_OPIMM, rv_decode_pkg::OPCODE_OP: begin
        decoder_ctrl_o.alu_en       = 1'b1;
        decoder_ctrl_o.rf_we        = 1'b1;
        decoder_ctrl_o.rf_re        = (opcode == rv_decode_pkg::OPCODE_OP) ? 2'b11 : 2'b01;
        decoder_ctrl_o.op_b_mux_sel = (opcode == rv_decode_pkg::OPCODE_OP) ?
                                      rv_decode_pkg::OP_B_REG : rv_decode_pkg::OP_B_IMM;
        unique case (funct3)
          3'b000:  decoder_ctrl_o.alu_operator =
                     (opcode == rv_decode_pkg::OPCODE_OP && funct7[5]) ?
                     rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
          3'b001:  decoder_ctrl_o.alu_operator = rv_decode_pkg::ALU_SLL;
          3'b010:  decoder_ctrl_o.alu_operator = rv_decode_pkg::ALU_SLT;
          3'b011:  decoder_ctrl_o.alu_operator = rv_decode_pkg::ALU_SLTU;
          3'b100:  decoder_ctrl_o.alu_operator = rv_decode_pkg::ALU_XOR;
          3'b101:  decoder_ctrl_o.alu_operator = funct7[5] ? rv_decode_pkg::ALU_SRA :
                                                             rv_decode_pkg::ALU_SRL;
          3'b110:  decoder_ctrl_o.alu_operator = rv_decode_pkg::ALU_OR;
          default: decoder_ctrl_o.alu_operator = rv_decode_pkg::ALU_AND;
        endcase
        // funct7 must be 0, or 0x20 on SUB and SRA only
        // OP-IMM checks it for shifts alone
        if (opcode == rv_decode_pkg::OPCODE_OP || funct3[1:0] == 2'b01) begin
          if ((funct7 & 7'b1011111) != 7'b0 ||
              (funct7[5] && funct3 != 3'b101 &&
               !(opcode == rv_decode_pkg::OPCODE_OP && funct3 == 3'b000))) begin
            decoder_ctrl_o = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
          end
        end
      end

      rv_decode_pkg::OPCODE_FENCE: begin
        unique case (funct3)
          3'b000:  ;                                            // FENCE is a no-op here
          3'b001:  decoder_ctrl_o.fencei_insn = 1'b1;
          default: decoder_ctrl_o = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
        endcase
      end

      rv_decode_pkg::OPCODE_SYSTEM: begin
        if (funct3 == 3'b000) begin
          // Privileged ops need rs1 = rd = 0
          unique case ({instr_rdata_i[31:20], instr_rdata_i[19:15] | instr_rdata_i[11:7]})
            {12'h000, 5'd0}: decoder_ctrl_o.ecall_insn = 1'b1;
            {12'h001, 5'd0}: decoder_ctrl_o.ebrk_insn  = 1'b1;
            {12'h302, 5'd0}: decoder_ctrl_o.mret_insn  = 1'b1;
            {12'h7b2, 5'd0}: decoder_ctrl_o.dret_insn  = 1'b1;
            {12'h105, 5'd0}: decoder_ctrl_o.wfi_insn   = 1'b1;
            default:         decoder_ctrl_o = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
          endcase
        end else begin
          decoder_ctrl_o.csr_en       = 1'b1;
          decoder_ctrl_o.rf_we        = 1'b1;
          decoder_ctrl_o.rf_re        = {1'b0, ~funct3[2]};     // CSRR*I uses zimm
          decoder_ctrl_o.op_b_mux_sel = rv_decode_pkg::OP_B_IMM; // CSR address
          decoder_ctrl_o.csr_op       = rv_decode_pkg::csr_opcode_e'(funct3[1:0]);
          if (funct3[1:0] == 2'b00) decoder_ctrl_o = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
        end
      end

      default: decoder_ctrl_o = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
    endcase
  end

  // OP words with funct7 = 1 belong to the M decoder
  always_comb begin
    assert (opcode != rv_decode_pkg::OPCODE_OP || funct7 != 7'b0000001 ||
            decoder_ctrl_o.illegal_insn)
      else $error("rv_i_decoder: MULDIV encoding decoded as legal");
  end

endmodule

/* design/rv_m_decoder.sv */
// RV32M multiply/divide decoder producing a control bundle
`timescale 1ns/1ps

module rv_m_decoder (
  input  logic [31:0]                  instr_rdata_i,
  output rv_decode_pkg::decoder_ctrl_t decoder_ctrl_o
);

  logic [2:0] funct3;
  logic       m_match;

  assign funct3  = instr_rdata_i[14:12];
  assign m_match = (instr_rdata_i[6:0] == rv_decode_pkg::OPCODE_OP) &&
                   (instr_rdata_i[31:25] == 7'b0000001);       // MULDIV funct7

  always_comb begin
    decoder_ctrl_o = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
    if (m_match) begin
      decoder_ctrl_o.illegal_insn = 1'b0;
      decoder_ctrl_o.rf_re        = 2'b11;                     // Both groups read rs1 and rs2
      decoder_ctrl_o.rf_we        = 1'b1;
      if (!funct3[2]) begin
        decoder_ctrl_o.mul_en       = 1'b1;
        decoder_ctrl_o.mul_operator = (funct3[1:0] == 2'b00) ? rv_decode_pkg::MUL :
                                                               rv_decode_pkg::MULH;
        unique case (funct3[1:0])
          2'b01:   decoder_ctrl_o.mul_signed_mode = 2'b11;     // MULH
          2'b10:   decoder_ctrl_o.mul_signed_mode = 2'b01;     // MULHSU, rs1 signed only
          default: decoder_ctrl_o.mul_signed_mode = 2'b00;     // MUL, MULHU
        endcase
      end else begin
        decoder_ctrl_o.div_en       = 1'b1;
        decoder_ctrl_o.div_operator = rv_decode_pkg::div_opcode_e'(funct3[1:0]);
      end
    end
  end

endmodule

/* design/rv_decoder.sv */
// Combining decoder with compressed-illegal override, suppression and ID/EX register
`timescale 1ns/1ps

module rv_decoder (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         instr_valid_i,
  input  logic                         illegal_c_insn_i,      // From compressed expander
  input  logic                         deassert_we_i,         // Stall or not active
  input  logic                         deassert_we_special_i, // Exception in IF
  input  rv_decode_pkg::decoder_ctrl_t i_ctrl_i,
  input  rv_decode_pkg::decoder_ctrl_t m_ctrl_i,
  output rv_decode_pkg::id_ex_t        id_ex_o
);

  rv_decode_pkg::decoder_ctrl_t ctrl_subdec; // Winning sub-decoder
  rv_decode_pkg::decoder_ctrl_t ctrl_mux;    // After compressed-illegal override
  rv_decode_pkg::decoder_ctrl_t ctrl_supp;   // After suppression
  rv_decode_pkg::decoder_ctrl_t ctrl_idle;
  rv_decode_pkg::id_ex_t        id_ex_d;
  logic                         deassert_any;

  //////////////////////////////////////////////////////////////////////////
  // Select and override
  //////////////////////////////////////////////////////////////////////////
  always_comb begin
    if (!m_ctrl_i.illegal_insn) begin
      ctrl_subdec = m_ctrl_i;                         // M has priority
    end else if (!i_ctrl_i.illegal_insn) begin
      ctrl_subdec = i_ctrl_i;
    end else begin
      ctrl_subdec = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
    end
  end

  assign ctrl_mux = illegal_c_insn_i ? rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN : ctrl_subdec;

  //////////////////////////////////////////////////////////////////////////
  // Suppression
  //////////////////////////////////////////////////////////////////////////
  assign deassert_any = deassert_we_i || deassert_we_special_i;

  always_comb begin
    ctrl_supp = ctrl_mux;
    if (deassert_any) begin
      ctrl_supp.alu_en             = 1'b0;
      ctrl_supp.mul_en             = 1'b0;
      ctrl_supp.div_en             = 1'b0;
      ctrl_supp.lsu_en             = 1'b0;
      ctrl_supp.rf_we              = 1'b0;
      ctrl_supp.csr_op             = rv_decode_pkg::CSR_OP_READ;
      ctrl_supp.ctrl_transfer_insn = rv_decode_pkg::BRANCH_NONE;
    end
    if (deassert_we_special_i) begin
      ctrl_supp.mret_insn    = 1'b0;
      ctrl_supp.dret_insn    = 1'b0;
      ctrl_supp.ebrk_insn    = 1'b0;
      ctrl_supp.ecall_insn   = 1'b0;
      ctrl_supp.wfi_insn     = 1'b0;
      ctrl_supp.fencei_insn  = 1'b0;
      ctrl_supp.illegal_insn = 1'b0;
    end
  end

  // Bundle loaded with no valid instruction, also the reset value
  always_comb begin
    ctrl_idle = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
    ctrl_idle.illegal_insn = 1'b0;
  end

  always_comb begin
    id_ex_d.valid                  = instr_valid_i;
    id_ex_d.ctrl                   = instr_valid_i ? ctrl_supp : ctrl_idle;
    id_ex_d.rf_we_raw              = instr_valid_i && ctrl_mux.rf_we;   // Pre-suppression
    id_ex_d.lsu_en_raw             = instr_valid_i && ctrl_mux.lsu_en;
    id_ex_d.ctrl_transfer_insn_raw = instr_valid_i ? ctrl_mux.ctrl_transfer_insn :
                                                     rv_decode_pkg::BRANCH_NONE;
  end

  //////////////////////////////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      id_ex_o <= '{valid: 1'b0, ctrl: ctrl_idle, rf_we_raw: 1'b0, lsu_en_raw: 1'b0,
                   ctrl_transfer_insn_raw: rv_decode_pkg::BRANCH_NONE};
    end else begin
      id_ex_o <= id_ex_d;
    end
  end

  // At most one sub-decoder claims a word
  a_one_subdec: assert property (@(posedge clk_i) disable iff (reset_i)
    i_ctrl_i.illegal_insn || m_ctrl_i.illegal_insn)
    else $error("rv_decoder: I and M decoders both legal");

  a_special_clears_illegal: assert property (@(posedge clk_i) disable iff (reset_i)
    deassert_we_special_i |=> !id_ex_o.ctrl.illegal_insn)
    else $error("rv_decoder: illegal_insn survived deassert_we_special");

  a_reset_valid: assert property (@(posedge clk_i) reset_i |=> !id_ex_o.valid)
    else $error("rv_decoder: valid set after reset");

endmodule

/* design/rv_decode_top.sv */
// Decode stage top level with I and M sub-decoders feeding the combining decoder
`timescale 1ns/1ps

module rv_decode_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  instr_valid_i,
  input  logic [31:0]           instr_rdata_i,         // From IF/ID
  input  logic                  illegal_c_insn_i,
  input  logic                  deassert_we_i,
  input  logic                  deassert_we_special_i,
  output rv_decode_pkg::id_ex_t id_ex_o
);

  rv_decode_pkg::decoder_ctrl_t i_ctrl; // RV32I bundle
  rv_decode_pkg::decoder_ctrl_t m_ctrl; // RV32M bundle

  // Both sub-decoders see the same word in parallel
  rv_i_decoder i_decoder_i (
    .instr_rdata_i  (instr_rdata_i),
    .decoder_ctrl_o (i_ctrl)
  );

  rv_m_decoder m_decoder_i (
    .instr_rdata_i  (instr_rdata_i),
    .decoder_ctrl_o (m_ctrl)
  );

  rv_decoder decoder_i (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .instr_valid_i         (instr_valid_i),
    .illegal_c_insn_i      (illegal_c_insn_i),
    .deassert_we_i         (deassert_we_i),
    .deassert_we_special_i (deassert_we_special_i),
    .i_ctrl_i              (i_ctrl),
    .m_ctrl_i              (m_ctrl),
    .id_ex_o               (id_ex_o)
  );

endmodule

/* verification/tb_clk_gen.sv */
// Testbench clock and synchronous reset generator
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;  // 20 ns period
  end

  // Reset held for 8 rising edges, released on the edge
  initial begin
    reset_o <= 1'b1;
    repeat (8) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

/* verification/tb_decode_top.sv */
// Table-driven testbench for the decode stage: stimulus table, compare tasks, watchdog
`timescale 1ns/1ps

module tb_decode_top;

  typedef rv_decode_pkg::decoder_ctrl_t ctrl_t;
  typedef rv_decode_pkg::id_ex_t        id_ex_t;

  typedef struct packed {
    logic [31:0] instr;
    logic [3:0]  ctl;  // valid, illegal_c, deassert_we, deassert_we_special
    logic        rnd;  // Random word, checked by the opcode rule only
    id_ex_t      exp;
  } entry_t;

  logic        clk;
  logic        reset;
  logic        instr_valid;
  logic [31:0] instr_rdata;
  logic        illegal_c_insn;
  logic        deassert_we;
  logic        deassert_we_special;
  id_ex_t      id_ex;

  entry_t tbl[$];
  string  names[$];
  int     seed = 40;
  int     n_random = 50;
  int     ctrl_errs, id_ex_errs, flag_errs, other_errs;

  tb_clk_gen clk_gen_i (.clk_o(clk), .reset_o(reset));

  rv_decode_top dut_i (
    .clk_i                 (clk),
    .reset_i               (reset),
    .instr_valid_i         (instr_valid),
    .instr_rdata_i         (instr_rdata),
    .illegal_c_insn_i      (illegal_c_insn),
    .deassert_we_i         (deassert_we),
    .deassert_we_special_i (deassert_we_special),
    .id_ex_o               (id_ex)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Expected bundles
  ////////////////////////////////////////////////////////////////////////////
  // en order is alu, mul, div, lsu, csr
  function automatic ctrl_t mk(logic [4:0] en, logic rf_we, logic [1:0] rf_re,
                               rv_decode_pkg::branch_e xfer);
    ctrl_t c;
    c = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
    c.illegal_insn = 1'b0;
    {c.alu_en, c.mul_en, c.div_en, c.lsu_en, c.csr_en} = en;
    c.rf_we = rf_we;
    c.rf_re = rf_re;
    c.ctrl_transfer_insn = xfer;
    return c;
  endfunction

  // Flags in order mret, dret, ebrk, ecall, wfi, fencei
  function automatic ctrl_t special(logic [5:0] flags);
    ctrl_t c;
    c = mk(5'b00000, 1'b0, 2'b00, rv_decode_pkg::BRANCH_NONE);
    {c.mret_insn, c.dret_insn, c.ebrk_insn, c.ecall_insn, c.wfi_insn, c.fencei_insn} = flags;
    return c;
  endfunction

  // exp is the stage output, dec the bundle before suppression (raw fields)
  task automatic add_entry(string name, logic [31:0] instr, logic [3:0] ctl, ctrl_t exp,
                           ctrl_t dec);
    entry_t e;
    e.instr = instr;
    e.ctl = ctl;
    e.rnd = 1'b0;
    e.exp.valid = ctl[3];
    e.exp.ctrl = exp;
    e.exp.rf_we_raw = ctl[3] & dec.rf_we;
    e.exp.lsu_en_raw = ctl[3] & dec.lsu_en;
    e.exp.ctrl_transfer_insn_raw = ctl[3] ? dec.ctrl_transfer_insn : rv_decode_pkg::BRANCH_NONE;
    tbl.push_back(e);
    names.push_back(name);
  endtask

  task automatic build_table();
    ctrl_t c;
    ctrl_t s;
    ctrl_t ill;
    ctrl_t idle;
    ill = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
    idle = mk(5'b00000, 1'b0, 2'b00, rv_decode_pkg::BRANCH_NONE);
    c = mk(5'b10000, 1'b1, 2'b01, rv_decode_pkg::BRANCH_NONE);     // addi x1, x2, 5
    c.op_b_mux_sel = rv_decode_pkg::OP_B_IMM;
    add_entry("ADDI", 32'h00510093, 4'b1000, c, c);
    s = c;
    s.alu_en = 1'b0;
    s.rf_we = 1'b0;
    add_entry("ADDI stalled", 32'h00510093, 4'b1010, s, c);
    add_entry("ADDI compressed illegal", 32'h00510093, 4'b1100, ill, ill);
    add_entry("ADDI not valid", 32'h00510093, 4'b0000, idle, idle);
    c = mk(5'b10000, 1'b1, 2'b11, rv_decode_pkg::BRANCH_NONE);     // sub x3, x1, x2
    c.alu_operator = rv_decode_pkg::ALU_SUB;
    add_entry("SUB", 32'h402081b3, 4'b1000, c, c);
    c = mk(5'b00010, 1'b1, 2'b01, rv_decode_pkg::BRANCH_NONE);     // lw x5, 8(x2)
    c.op_b_mux_sel = rv_decode_pkg::OP_B_IMM;
    c.lsu_type = 2'b10;
    c.lsu_sign_ext = 1'b1;
    add_entry("LW", 32'h00812283, 4'b1000, c, c);
    s = c;
    s.lsu_en = 1'b0;
    s.rf_we = 1'b0;
    add_entry("LW stalled", 32'h00812283, 4'b1010, s, c);
    c = mk(5'b00010, 1'b0, 2'b11, rv_decode_pkg::BRANCH_NONE);     // sb x6, 4(x2)
    c.lsu_we = 1'b1;
    c.op_b_mux_sel = rv_decode_pkg::OP_B_IMM;
    c.imm_mux_sel = rv_decode_pkg::IMM_S;
    add_entry("SB", 32'h00610223, 4'b1000, c, c);
    c = mk(5'b10000, 1'b0, 2'b11, rv_decode_pkg::BRANCH_COND);     // beq x1, x2, +8
    c.alu_operator = rv_decode_pkg::ALU_EQ;
    c.imm_mux_sel = rv_decode_pkg::IMM_B;
    add_entry("BEQ", 32'h00208463, 4'b1000, c, c);
    c = mk(5'b10000, 1'b1, 2'b00, rv_decode_pkg::BRANCH_JAL);      // jal x1, +16
    c.op_a_mux_sel = rv_decode_pkg::OP_A_PC;
    c.op_b_mux_sel = rv_decode_pkg::OP_B_IMM;
    c.imm_mux_sel = rv_decode_pkg::IMM_J;
    add_entry("JAL", 32'h010000ef, 4'b1000, c, c);
    s = c;
    s.alu_en = 1'b0;
    s.rf_we = 1'b0;
    s.ctrl_transfer_insn = rv_decode_pkg::BRANCH_NONE;             // Raw kind stays JAL
    add_entry("JAL stalled", 32'h010000ef, 4'b1010, s, c);
    c = mk(5'b10000, 1'b1, 2'b01, rv_decode_pkg::BRANCH_JALR);     // jalr x1, 0(x5)
    c.op_b_mux_sel = rv_decode_pkg::OP_B_IMM;
    add_entry("JALR", 32'h000280e7, 4'b1000, c, c);
    c = mk(5'b10000, 1'b1, 2'b00, rv_decode_pkg::BRANCH_NONE);     // lui x7, 0x12345
    c.op_a_mux_sel = rv_decode_pkg::OP_A_ZERO;
    c.op_b_mux_sel = rv_decode_pkg::OP_B_IMM;
    c.imm_mux_sel = rv_decode_pkg::IMM_U;
    add_entry("LUI", 32'h123453b7, 4'b1000, c, c);
    c = mk(5'b00001, 1'b1, 2'b01, rv_decode_pkg::BRANCH_NONE);     // csrrs x8, mstatus, x0
    c.op_b_mux_sel = rv_decode_pkg::OP_B_IMM;
    c.csr_op = rv_decode_pkg::CSR_OP_SET;
    add_entry("CSRRS", 32'h30002473, 4'b1000, c, c);
    s = c;
    s.rf_we = 1'b0;
    s.csr_op = rv_decode_pkg::CSR_OP_READ;
    add_entry("CSRRS stalled", 32'h30002473, 4'b1010, s, c);
    c = special(6'b000100);
    add_entry("ECALL", 32'h00000073, 4'b1000, c, c);
    add_entry("ECALL stalled", 32'h00000073, 4'b1010, c, c);       // Flag survives a stall
    add_entry("ECALL special", 32'h00000073, 4'b1001, idle, c);
    add_entry("EBREAK", 32'h00100073, 4'b1000, special(6'b001000), special(6'b001000));
    add_entry("MRET", 32'h30200073, 4'b1000, special(6'b100000), special(6'b100000));
    add_entry("DRET", 32'h7b200073, 4'b1000, special(6'b010000), special(6'b010000));
    add_entry("WFI", 32'h10500073, 4'b1000, special(6'b000010), special(6'b000010));
    add_entry("FENCE.I", 32'h0000100f, 4'b1000, special(6'b000001), special(6'b000001));
    c = mk(5'b01000, 1'b1, 2'b11, rv_decode_pkg::BRANCH_NONE);     // mul x3, x1, x2
    add_entry("MUL", 32'h022081b3, 4'b1000, c, c);
    c.mul_operator = rv_decode_pkg::MULH;                          // Unsigned, mode stays 00
    add_entry("MULHU", 32'h0220b1b3, 4'b1000, c, c);
    c = mk(5'b00100, 1'b1, 2'b11, rv_decode_pkg::BRANCH_NONE);
    add_entry("DIV", 32'h0220c1b3, 4'b1000, c, c);
    c.div_operator = rv_decode_pkg::REMU;
    add_entry("REMU", 32'h0220f1b3, 4'b1000, c, c);
    add_entry("OP funct7 0x02", 32'h042081b3, 4'b1000, ill, ill);
    add_entry("unknown opcode", 32'hffffffff, 4'b1000, ill, ill);
    add_entry("unknown opcode special", 32'hffffffff, 4'b1001, idle, ill);
    add_entry("MUL not valid", 32'h022081b3, 4'b0100, idle, idle);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_ctrl(string name, ctrl_t act, ctrl_t exp);
    if (act !== exp) begin
      ctrl_errs++;
      $display("MISMATCH %s: act=%h exp=%h", name, act, exp);
    end
  endtask

  // Valid and raw fields here, bundle through check_ctrl
  task automatic check_id_ex(string name, id_ex_t act, id_ex_t exp);
    id_ex_t a;
    id_ex_t e;
    a = act;
    e = exp;
    a.ctrl = '0;
    e.ctrl = '0;
    if (a !== e) begin
      id_ex_errs++;
      $display("MISMATCH %s id_ex_o: act=%h exp=%h", name, a, e);
    end
    check_ctrl({name, " id_ex_o.ctrl"}, act.ctrl, exp.ctrl);
  endtask

  task automatic check_flag(string name, logic act, logic exp);
    if (act !== exp) begin
      flag_errs++;
      $display("MISMATCH %s: act=%h exp=%h", name, act, exp);
    end
  endtask

  // Legal from exactly one sub-decoder, or the full illegal bundle
  task automatic check_random(logic [31:0] word, id_ex_t act);
    string tag;
    logic  is_m;
    logic  known;
    tag = $sformatf("random %h", word);
    is_m = (word[6:0] == rv_decode_pkg::OPCODE_OP) && (word[31:25] == 7'h01);
    known = word[6:0] inside {rv_decode_pkg::OPCODE_OP, rv_decode_pkg::OPCODE_OPIMM,
      rv_decode_pkg::OPCODE_LOAD, rv_decode_pkg::OPCODE_STORE, rv_decode_pkg::OPCODE_BRANCH,
      rv_decode_pkg::OPCODE_JAL, rv_decode_pkg::OPCODE_JALR, rv_decode_pkg::OPCODE_LUI,
      rv_decode_pkg::OPCODE_AUIPC, rv_decode_pkg::OPCODE_SYSTEM, rv_decode_pkg::OPCODE_FENCE};
    check_flag({tag, " id_ex_o.valid"}, act.valid, 1'b1);
    if (!known || is_m) check_flag({tag, " illegal_insn"}, act.ctrl.illegal_insn, !known);
    if (act.ctrl.illegal_insn) begin
      check_ctrl({tag, " id_ex_o.ctrl"}, act.ctrl, rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN);
    end else begin
      check_flag({tag, " mul_en|div_en"}, act.ctrl.mul_en | act.ctrl.div_en, is_m);
      if (is_m) check_flag({tag, " alu_en"}, act.ctrl.alu_en, 1'b0);
    end
  endtask

  task automatic drive(entry_t e);
    instr_rdata <= e.instr;
    {instr_valid, illegal_c_insn, deassert_we, deassert_we_special} <= e.ctl;
  endtask

  task automatic report_counts();
    $display("Errors: ctrl %0d, id_ex %0d, flag %0d, other %0d",
             ctrl_errs, id_ex_errs, flag_errs, other_errs);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    entry_t      idle_e;
    entry_t      r;
    id_ex_t      rst_exp;
    logic [31:0] word;
    int          timeout_ns;
    instr_rdata <= 32'h00510093;         // Valid ADDI held against reset
    instr_valid <= 1'b1;
    illegal_c_insn <= 1'b0;
    deassert_we <= 1'b0;
    deassert_we_special <= 1'b0;
    build_table();
    for (int i = 0; i < n_random; i++) begin
      word = $random(seed);
      if (i[0]) word[6:0] = rv_decode_pkg::OPCODE_OP;   // Steer half onto OP
      if (i[1:0] == 2'b01) word[31:25] = 7'h01;         // and some onto MULDIV
      r = '0;
      r.instr = word;
      r.ctl = 4'b1000;
      r.rnd = 1'b1;
      tbl.push_back(r);
      names.push_back("random");
    end
    timeout_ns = (tbl.size() + 20) * 20;
    fork
      begin
        #(timeout_ns);
        other_errs++;
        $display("Timeout: run did not complete within %0d ns", timeout_ns);
        report_counts();
        $display("Simulation finished: FAIL");
        $finish;
      end
    join_none
    idle_e = '0;
    rst_exp = '0;
    rst_exp.ctrl = mk(5'b00000, 1'b0, 2'b00, rv_decode_pkg::BRANCH_NONE);
    // Reset dominates a valid word
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_id_ex("during reset", id_ex, rst_exp);
    @(posedge clk);
    drive(idle_e);
    wait (!reset);
    @(posedge clk);
    @(negedge clk);
    check_id_ex("after reset", id_ex, rst_exp);
    // One entry per cycle, each checked a cycle after it is driven
    for (int k = 0; k <= tbl.size(); k++) begin
      @(posedge clk);
      if (k < tbl.size()) drive(tbl[k]);
      else drive(idle_e);
      if (k > 0) begin
        @(negedge clk);
        if (tbl[k-1].rnd) check_random(tbl[k-1].instr, id_ex);
        else check_id_ex(names[k-1], id_ex, tbl[k-1].exp);
      end
    end
    report_counts();
    if (ctrl_errs + id_ex_errs + flag_errs + other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* list.f */
design/rv_decode_pkg.sv
design/rv_i_decoder.sv
design/rv_m_decoder.sv
design/rv_decoder.sv
design/rv_decode_top.sv
verification/tb_clk_gen.sv
verification/tb_decode_top.sv

/* Makefile */
VERILATOR := verilator
TOP       := tb_decode_top
FILELIST  := list.f
FLAGS     := --timing --assert
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
